// File: hw/issue_params.svh
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// Datapath and register file
`define XLEN      32
`define NUM_REGS  32

// Reorder buffer tags with tag 0 reserved for "no dependency"
`define ROB_IDX_W 4
`define ROB_DEPTH (1 << `ROB_IDX_W)

// RV32I major opcodes handled at issue
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011

`endif

// File: hw/issue_pkg.sv
`include "issue_params.svh"

package issue_pkg;

    typedef logic [`XLEN-1:0]              word_t;
    typedef logic [`ROB_IDX_W-1:0]         rob_id_t;
    typedef logic [$clog2(`NUM_REGS)-1:0]  reg_idx_t;
    typedef logic [3:0]                    alu_op_t;   // {instr[30], func3}

    // One fetched instruction
    typedef struct packed {
        word_t instr;
        word_t pc;
    } fetch_pkt_t;

    // Resolved source operand whose value counts only when tag is 0
    typedef struct packed {
        word_t   value;
        rob_id_t tag;
    } operand_t;

    typedef struct packed {
        rob_id_t tag;
        word_t   value;
    } cdb_t;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        alu_op_t  alu_op;
        word_t    imm;          // Operand k when imm_as_k
        logic     pc_as_j;      // AUIPC
        logic     imm_as_k;
        word_t    known_value;  // LUI result or link address
        word_t    jump_target;
        word_t    pc_plus4;
        logic     uses_alu;
        logic     value_known;
        logic     writes_rd;
        logic     redirect;
        logic     legal;
    } decoded_t;

    typedef struct packed {
        logic     value_ready;
        word_t    value;
        reg_idx_t dest;
    } rob_entry_t;

    typedef struct packed {
        alu_op_t op;
        word_t   vj;
        word_t   vk;
        rob_id_t qj;
        rob_id_t qk;
        rob_id_t dest;
    } alu_entry_t;

    typedef struct packed {
        reg_idx_t reg_id;
        rob_id_t  rob_id;
    } rename_wr_t;

    typedef enum logic [1:0] {
        ST_TRY_ISSUE,
        ST_ISSUE_HELD,
        ST_SKIP_ONE
    } issue_state_e;

endpackage

// File: hw/fetch_slot.sv
`timescale 1ns/10ps

// Keeps a copy of an instruction that could not issue and replays it
// until the controller lets it go
module fetch_slot (
    input  logic                 clk_in,
    input  logic                 rst,
    input  logic                 flush,
    input  issue_pkg::fetch_pkt_t instr,
    input  logic                 capture,
    input  logic                 use_held,
    output issue_pkg::fetch_pkt_t cur
);

    issue_pkg::fetch_pkt_t held;

    // Capture happens on the stall cycle while the fetcher is redirected
    always_ff @(posedge clk_in) begin
        if (rst || flush) begin
            held <= '0;
        end else if (capture) begin
            held <= instr;
        end
    end

    // Held copy wins while retrying
    always_comb begin
        if (use_held) begin
            cur = held;
        end else begin
            cur = instr;   // Live path from fetcher
        end
    end

endmodule

// File: hw/rv_field_decode.sv
`timescale 1ns/10ps

`include "issue_params.svh"

module rv_field_decode (
    input  issue_pkg::fetch_pkt_t pkt,
    output issue_pkg::decoded_t   dec
);

    logic [6:0]       opcode;
    logic [2:0]       func3;
    issue_pkg::word_t imm_i;
    issue_pkg::word_t imm_u;
    issue_pkg::word_t imm_j;
    issue_pkg::word_t shamt;
    logic             is_shift;

    assign opcode = pkt.instr[6:0];
    assign func3  = pkt.instr[14:12];

    // Immediate formats
    assign imm_i = {{(`XLEN-12){pkt.instr[31]}}, pkt.instr[31:20]};
    assign imm_u = {pkt.instr[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){pkt.instr[31]}}, pkt.instr[31], pkt.instr[19:12],
                    pkt.instr[20], pkt.instr[30:21], 1'b0};
    assign shamt = {{(`XLEN-5){1'b0}}, pkt.instr[24:20]};

    assign is_shift = (func3 == 3'b001) || (func3 == 3'b101);  // SLLI, SRLI, SRAI

    always_comb begin
        dec = '0;
        dec.rs1         = pkt.instr[19:15];
        dec.rs2         = pkt.instr[24:20];
        dec.rd          = pkt.instr[11:7];
        dec.pc_plus4    = pkt.pc + issue_pkg::word_t'(4);
        dec.jump_target = pkt.pc + imm_j;

        case (opcode)
            `OPC_LUI: begin
                dec.legal       = 1'b1;
                dec.writes_rd   = 1'b1;
                dec.value_known = 1'b1;
                dec.known_value = imm_u;
            end
            `OPC_AUIPC: begin
                dec.legal     = 1'b1;
                dec.writes_rd = 1'b1;
                dec.uses_alu  = 1'b1;
                dec.alu_op    = 4'b0000;  // Plain add
                dec.pc_as_j   = 1'b1;
                dec.imm_as_k  = 1'b1;
                dec.imm       = imm_u;
            end
            `OPC_JAL: begin
                dec.legal       = 1'b1;
                dec.writes_rd   = 1'b1;
                dec.value_known = 1'b1;
                dec.redirect    = 1'b1;
                dec.known_value = dec.pc_plus4;  // Link address
            end
            `OPC_OP_IMM: begin
                dec.legal     = 1'b1;
                dec.writes_rd = 1'b1;
                dec.uses_alu  = 1'b1;
                dec.imm_as_k  = 1'b1;
                // Bit 30 only means something for the shifts
                if (is_shift) begin
                    dec.alu_op = {pkt.instr[30], func3};
                    dec.imm    = shamt;
                end else begin
                    dec.alu_op = {1'b0, func3};
                    dec.imm    = imm_i;
                end
            end
            `OPC_OP: begin
                dec.legal     = 1'b1;
                dec.writes_rd = 1'b1;
                dec.uses_alu  = 1'b1;
                dec.alu_op    = {pkt.instr[30], func3};  // Operand k from rs2
            end
            default: begin
                dec.legal = 1'b0;  // Nothing issues
            end
        endcase
    end

endmodule

// File: hw/operand_resolve.sv
`timescale 1ns/10ps

`include "issue_params.svh"

// Looks up one source register and returns either its value or the
// reorder buffer tag it still waits on
module operand_resolve (
    input  issue_pkg::reg_idx_t   src,
    input  issue_pkg::rob_id_t    rename_tags [0:`NUM_REGS-1],
    input  issue_pkg::word_t      reg_data [0:`NUM_REGS-1],
    input  issue_pkg::word_t      rob_values [0:`ROB_DEPTH-1],
    input  logic [`ROB_DEPTH-1:0] rob_ready,
    input  issue_pkg::cdb_t       cdb_alu,
    input  issue_pkg::cdb_t       cdb_mem,
    input  logic                  last_rob_wr_en,
    input  issue_pkg::rob_entry_t last_rob_entry,
    input  issue_pkg::rename_wr_t last_rename,
    output issue_pkg::operand_t   opnd
);

    issue_pkg::rob_id_t rn_tag;
    logic               fwd_hit;

    assign rn_tag = rename_tags[src];

    // Rename table has not seen last cycle's dispatch yet
    assign fwd_hit = last_rob_wr_en && (last_rob_entry.dest == src) && (src != '0);

    always_comb begin
        opnd = '0;
        if (fwd_hit) begin
            if (last_rob_entry.value_ready) begin
                opnd.value = last_rob_entry.value;
            end else begin
                opnd.tag = last_rename.rob_id;
            end
        end else if (rn_tag == '0) begin
            opnd.value = reg_data[src];  // Committed value
        end else if (cdb_alu.tag == rn_tag) begin
            opnd.value = cdb_alu.value;
        end else if (cdb_mem.tag == rn_tag) begin
            opnd.value = cdb_mem.value;
        end else if (rob_ready[rn_tag]) begin
            // Finished but not yet committed
            opnd.value = rob_values[rn_tag];
        end else begin
            opnd.tag = rn_tag;
        end
    end

endmodule

// File: hw/issue_ctrl.sv
`timescale 1ns/10ps

module issue_ctrl (
    input  logic                  clk_in,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  instr_valid,
    input  logic                  rob_full,
    input  logic                  alu_full,
    input  issue_pkg::fetch_pkt_t cur,
    input  issue_pkg::decoded_t   dec,
    input  issue_pkg::operand_t   op1,
    input  issue_pkg::operand_t   op2,
    input  issue_pkg::rob_id_t    rob_tail,
    output logic                  capture,
    output logic                  use_held,
    output logic                  fetch_redirect,
    output issue_pkg::word_t      fetch_pc,
    output logic                  rob_wr_en,
    output issue_pkg::rob_entry_t rob_entry,
    output logic                  alu_wr_en,
    output issue_pkg::alu_entry_t alu_entry,
    output logic                  rename_wr_en,
    output issue_pkg::rename_wr_t rename_wr
);

    issue_pkg::issue_state_e state;
    issue_pkg::issue_state_e state_nxt;

    logic attempt;   // An instruction is presented to the dispatch logic
    logic stall;
    logic do_issue;

    issue_pkg::rob_entry_t rob_entry_nxt;
    issue_pkg::alu_entry_t alu_entry_nxt;

    assign attempt  = ((state == issue_pkg::ST_TRY_ISSUE) && instr_valid)
                      || (state == issue_pkg::ST_ISSUE_HELD);
    assign stall    = dec.legal && (rob_full || (dec.uses_alu && alu_full));
    assign do_issue = attempt && dec.legal && !stall;

    // Only a live instruction needs capturing since a held one stays put
    assign capture  = (state == issue_pkg::ST_TRY_ISSUE) && instr_valid && stall;
    assign use_held = (state == issue_pkg::ST_ISSUE_HELD);

    always_comb begin
        state_nxt = issue_pkg::ST_TRY_ISSUE;
        case (state)
            issue_pkg::ST_TRY_ISSUE,
            issue_pkg::ST_ISSUE_HELD: begin
                if (attempt && stall) begin
                    state_nxt = issue_pkg::ST_ISSUE_HELD;
                end else if (do_issue && dec.redirect) begin
                    state_nxt = issue_pkg::ST_SKIP_ONE;  // JAL shadow
                end
            end
            default: begin
                state_nxt = issue_pkg::ST_TRY_ISSUE;
            end
        endcase
    end

    always_comb begin
        rob_entry_nxt             = '0;
        rob_entry_nxt.value_ready = dec.value_known;
        rob_entry_nxt.dest        = dec.rd;
        if (dec.value_known) begin
            rob_entry_nxt.value = dec.known_value;
        end

        alu_entry_nxt.op   = dec.alu_op;
        alu_entry_nxt.dest = rob_tail;
        // pc and immediate operands never wait on anything
        if (dec.pc_as_j) begin
            alu_entry_nxt.vj = cur.pc;
            alu_entry_nxt.qj = '0;
        end else begin
            alu_entry_nxt.vj = op1.value;
            alu_entry_nxt.qj = op1.tag;
        end
        if (dec.imm_as_k) begin
            alu_entry_nxt.vk = dec.imm;
            alu_entry_nxt.qk = '0;
        end else begin
            alu_entry_nxt.vk = op2.value;
            alu_entry_nxt.qk = op2.tag;
        end
    end

    // State and enables
    always_ff @(posedge clk_in) begin
        if (rst || flush) begin
            state          <= issue_pkg::ST_TRY_ISSUE;
            fetch_redirect <= 1'b0;
            rob_wr_en      <= 1'b0;
            alu_wr_en      <= 1'b0;
            rename_wr_en   <= 1'b0;
        end else begin
            state          <= state_nxt;
            fetch_redirect <= attempt && (stall || (do_issue && dec.redirect));
            rob_wr_en      <= do_issue;
            alu_wr_en      <= do_issue && dec.uses_alu;
            rename_wr_en   <= do_issue && dec.writes_rd && (dec.rd != '0);  // x0 never renamed
        end
    end

    // Payload qualified by the enables above
    always_ff @(posedge clk_in) begin
        if (attempt) begin
            fetch_pc <= stall ? dec.pc_plus4 : dec.jump_target;  // Refetch after the stall
        end
        if (do_issue) begin
            rob_entry        <= rob_entry_nxt;
            alu_entry        <= alu_entry_nxt;
            rename_wr.reg_id <= dec.rd;
            rename_wr.rob_id <= rob_tail;
        end
    end

endmodule

// File: hw/issue_unit.sv
`timescale 1ns/10ps

`include "issue_params.svh"

module issue_unit (
    input  logic                  clk_in,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  issue_pkg::fetch_pkt_t instr,
    input  issue_pkg::rob_id_t    rename_tags [0:`NUM_REGS-1],
    input  issue_pkg::word_t      reg_data [0:`NUM_REGS-1],
    input  issue_pkg::word_t      rob_values [0:`ROB_DEPTH-1],
    input  logic [`ROB_DEPTH-1:0] rob_ready,
    input  issue_pkg::cdb_t       cdb_alu,
    input  issue_pkg::cdb_t       cdb_mem,
    input  logic                  rob_full,
    input  logic                  alu_full,
    input  issue_pkg::rob_id_t    rob_tail,
    input  logic                  flush,
    output logic                  fetch_redirect,
    output issue_pkg::word_t      fetch_pc,
    output logic                  rob_wr_en,
    output issue_pkg::rob_entry_t rob_entry,
    output logic                  alu_wr_en,
    output issue_pkg::alu_entry_t alu_entry,
    output logic                  rename_wr_en,
    output issue_pkg::rename_wr_t rename_wr
);

    issue_pkg::fetch_pkt_t cur;
    issue_pkg::decoded_t   dec;
    issue_pkg::operand_t   op1;
    issue_pkg::operand_t   op2;
    logic                  capture;
    logic                  use_held;

    fetch_slot u_slot (
        .clk_in   (clk_in),
        .rst      (rst),
        .flush    (flush),
        .instr    (instr),
        .capture  (capture),
        .use_held (use_held),
        .cur      (cur)
    );

    rv_field_decode u_dec (
        .pkt (cur),
        .dec (dec)
    );

    // Both sources see last cycle's dispatch for back-to-back dependencies
    operand_resolve u_rs1 (
        .src            (dec.rs1),
        .rename_tags    (rename_tags),
        .reg_data       (reg_data),
        .rob_values     (rob_values),
        .rob_ready      (rob_ready),
        .cdb_alu        (cdb_alu),
        .cdb_mem        (cdb_mem),
        .last_rob_wr_en (rob_wr_en),
        .last_rob_entry (rob_entry),
        .last_rename    (rename_wr),
        .opnd           (op1)
    );

    operand_resolve u_rs2 (
        .src            (dec.rs2),
        .rename_tags    (rename_tags),
        .reg_data       (reg_data),
        .rob_values     (rob_values),
        .rob_ready      (rob_ready),
        .cdb_alu        (cdb_alu),
        .cdb_mem        (cdb_mem),
        .last_rob_wr_en (rob_wr_en),
        .last_rob_entry (rob_entry),
        .last_rename    (rename_wr),
        .opnd           (op2)
    );

    issue_ctrl u_ctrl (
        .clk_in         (clk_in),
        .rst            (rst),
        .flush          (flush),
        .instr_valid    (instr_valid),
        .rob_full       (rob_full),
        .alu_full       (alu_full),
        .cur            (cur),
        .dec            (dec),
        .op1            (op1),
        .op2            (op2),
        .rob_tail       (rob_tail),
        .capture        (capture),
        .use_held       (use_held),
        .fetch_redirect (fetch_redirect),
        .fetch_pc       (fetch_pc),
        .rob_wr_en      (rob_wr_en),
        .rob_entry      (rob_entry),
        .alu_wr_en      (alu_wr_en),
        .alu_entry      (alu_entry),
        .rename_wr_en   (rename_wr_en),
        .rename_wr      (rename_wr)
    );

endmodule

// File: bench/issue_tb.sv
`timescale 1ns/10ps

`include "issue_params.svh"

module issue_tb;

    localparam int NUM_CYCLES = 3000;
    localparam int TMO_LIMIT  = NUM_CYCLES + 200;

    // Expected outputs after one clock edge
    typedef struct packed {
        logic                  redirect;
        issue_pkg::word_t      fetch_pc;
        logic                  rob_wr;
        issue_pkg::rob_entry_t rob;
        logic                  alu_wr;
        issue_pkg::alu_entry_t alu;
        logic                  ren_wr;
        issue_pkg::rename_wr_t ren;
    } dispatch_t;

    logic                  clk_in = 1'b0;
    logic                  rst;
    logic                  flush;
    logic                  instr_valid;
    issue_pkg::fetch_pkt_t instr;
    issue_pkg::rob_id_t    rename_tags [0:`NUM_REGS-1];
    issue_pkg::word_t      reg_data [0:`NUM_REGS-1];
    issue_pkg::word_t      rob_values [0:`ROB_DEPTH-1];
    logic [`ROB_DEPTH-1:0] rob_ready;
    issue_pkg::cdb_t       cdb_alu;
    issue_pkg::cdb_t       cdb_mem;
    logic                  rob_full;
    logic                  alu_full;
    issue_pkg::rob_id_t    rob_tail;
    logic                  fetch_redirect;
    issue_pkg::word_t      fetch_pc;
    logic                  rob_wr_en;
    issue_pkg::rob_entry_t rob_entry;
    logic                  alu_wr_en;
    issue_pkg::alu_entry_t alu_entry;
    logic                  rename_wr_en;
    issue_pkg::rename_wr_t rename_wr;

    // Copies of the values driven in the current cycle
    issue_pkg::rob_id_t    t_tags [0:`NUM_REGS-1];
    issue_pkg::word_t      t_regs [0:`NUM_REGS-1];
    issue_pkg::word_t      t_rvals [0:`ROB_DEPTH-1];
    logic [`ROB_DEPTH-1:0] t_rready;
    issue_pkg::cdb_t       t_cdb_alu;
    issue_pkg::cdb_t       t_cdb_mem;

    // Reference model state
    issue_pkg::issue_state_e m_state;
    issue_pkg::fetch_pkt_t   m_held;
    logic                    m_last_wr;
    issue_pkg::rob_entry_t   m_last_rob;
    issue_pkg::rob_id_t      m_last_tag;

    dispatch_t   exp_pending;
    dispatch_t   exp_now;
    logic        chk_pending;
    logic        chk_now;
    logic [31:0] rand_state;
    logic        full_kind;
    int          full_left;
    int          cyc;
    int          n_checks;
    int          n_errors;
    int          tmo_cnt;

    issue_unit DUT (.*);

    always #10 clk_in = ~clk_in;

    function logic [31:0] next_rand();
        logic [15:0] hi;
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        hi = rand_state[31:16];   // Upper half only as low bits repeat too soon
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return {hi, rand_state[31:16]};
    endfunction

    // Source lookup in rule order
    function automatic issue_pkg::operand_t expect_operand(issue_pkg::reg_idx_t src);
        issue_pkg::operand_t o;
        issue_pkg::rob_id_t  tg;
        o  = '0;
        tg = t_tags[src];
        if (m_last_wr && (m_last_rob.dest == src) && (src != 5'd0)) begin
            if (m_last_rob.value_ready) begin
                o.value = m_last_rob.value;
            end else begin
                o.tag = m_last_tag;
            end
        end else if (tg == 4'd0) begin
            o.value = t_regs[src];
        end else if (t_cdb_alu.tag == tg) begin
            o.value = t_cdb_alu.value;
        end else if (t_cdb_mem.tag == tg) begin
            o.value = t_cdb_mem.value;
        end else if (t_rready[tg]) begin
            o.value = t_rvals[tg];
        end else begin
            o.tag = tg;
        end
        return o;
    endfunction

    function automatic dispatch_t expect_dispatch(issue_pkg::fetch_pkt_t p,
                                                  issue_pkg::operand_t o1,
                                                  issue_pkg::operand_t o2,
                                                  issue_pkg::rob_id_t tail,
                                                  logic try_it, logic rfull, logic afull);
        dispatch_t        d;
        logic [6:0]       opc;
        logic [2:0]       f3;
        issue_pkg::word_t imm_i;
        issue_pkg::word_t imm_u;
        issue_pkg::word_t imm_j;
        issue_pkg::word_t pc4;
        logic             legal;
        logic             use_alu;
        logic             known;
        logic             stall;
        logic             go;
        opc   = p.instr[6:0];
        f3    = p.instr[14:12];
        imm_i = {{20{p.instr[31]}}, p.instr[31:20]};
        imm_u = {p.instr[31:12], 12'h000};
        imm_j = {{12{p.instr[31]}}, p.instr[19:12], p.instr[20], p.instr[30:21], 1'b0};
        pc4   = p.pc + 32'd4;
        d       = '0;
        legal   = 1'b1;
        use_alu = 1'b0;
        known   = 1'b0;
        d.alu.dest = tail;
        d.alu.vj   = o1.value;
        d.alu.qj   = o1.tag;
        d.alu.vk   = o2.value;
        d.alu.qk   = o2.tag;
        case (opc)
            `OPC_LUI: begin
                known       = 1'b1;
                d.rob.value = imm_u;
            end
            `OPC_JAL: begin
                known       = 1'b1;
                d.rob.value = pc4;   // Link address
            end
            `OPC_AUIPC: begin
                use_alu  = 1'b1;
                d.alu.vj = p.pc;
                d.alu.qj = '0;
                d.alu.vk = imm_u;
                d.alu.qk = '0;
            end
            `OPC_OP_IMM: begin
                use_alu  = 1'b1;
                d.alu.qk = '0;
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    d.alu.op = {p.instr[30], f3};
                    d.alu.vk = {27'd0, p.instr[24:20]};   // Shamt
                end else begin
                    d.alu.op = {1'b0, f3};
                    d.alu.vk = imm_i;
                end
            end
            `OPC_OP: begin
                use_alu  = 1'b1;
                d.alu.op = {p.instr[30], f3};
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        stall = try_it && legal && (rfull || (use_alu && afull));
        go    = try_it && legal && !stall;
        d.redirect        = stall || (go && (opc == `OPC_JAL));
        d.fetch_pc        = stall ? pc4 : p.pc + imm_j;
        d.rob_wr          = go;
        d.rob.value_ready = known;
        d.rob.dest        = p.instr[11:7];
        d.alu_wr          = go && use_alu;
        d.ren_wr          = go && (p.instr[11:7] != 5'd0);
        d.ren.reg_id      = p.instr[11:7];
        d.ren.rob_id      = tail;
        return d;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Stimulus and reference model stepped once per clock edge
    always @(posedge clk_in) begin : drive
        issue_pkg::fetch_pkt_t pkt;
        issue_pkg::fetch_pkt_t sel;
        issue_pkg::operand_t   o1;
        issue_pkg::operand_t   o2;
        issue_pkg::rob_id_t    tail;
        dispatch_t             d;
        logic [31:0]           r;
        logic                  v;
        logic                  t_rst;
        logic                  t_flush;
        logic                  t_rfull;
        logic                  t_afull;
        logic                  try_it;
        exp_now = exp_pending;
        chk_now = chk_pending;
        cyc     = cyc + 1;

        for (int i = 0; i < `NUM_REGS; i++) begin
            r         = next_rand();
            t_tags[i] = (r[16] && i != 0) ? r[31:28] : 4'd0;   // About half renamed
            t_regs[i] = (i == 0) ? 32'd0 : next_rand();
        end
        for (int j = 0; j < `ROB_DEPTH; j++) begin
            t_rvals[j] = next_rand();
        end
        r               = next_rand();
        t_rready        = r[15:0];
        t_cdb_alu.tag   = t_tags[r[20:16]];   // Bus tags picked to hit often
        t_cdb_mem.tag   = t_tags[r[25:21]];
        t_cdb_alu.value = next_rand();
        t_cdb_mem.value = next_rand();

        // Full episodes of 1 to 4 cycles
        r = next_rand();
        if (full_left == 0 && r[3:0] == 4'd0) begin
            full_left = 1 + r[5:4];
            full_kind = r[6];
        end
        t_rfull = (full_left != 0) && full_kind;
        t_afull = (full_left != 0) && !full_kind;
        if (full_left != 0) begin
            full_left = full_left - 1;
        end

        r         = next_rand();
        pkt.instr = next_rand();
        pkt.pc    = next_rand() & 32'hffff_fffc;
        case (r[2:0])
            3'd0:    pkt.instr[6:0] = `OPC_LUI;
            3'd1:    pkt.instr[6:0] = `OPC_AUIPC;
            3'd2:    pkt.instr[6:0] = `OPC_JAL;
            3'd3,
            3'd4:    pkt.instr[6:0] = `OPC_OP_IMM;
            3'd5,
            3'd6:    pkt.instr[6:0] = `OPC_OP;
            default: pkt.instr[6:0] = 7'b1100011;   // Branch is not handled here
        endcase
        if (r[3]) begin
            pkt.instr[19:15] = m_last_rob.dest;   // Back-to-back dependency
        end
        if (r[4]) begin
            pkt.instr[24:20] = m_last_rob.dest;
        end
        v       = (r[6:5] != 2'b00);
        tail    = issue_pkg::rob_id_t'(1 + (r[11:7] % 15));
        t_flush = (r[19:14] == 6'd0);
        t_rst   = (cyc < 4);

        try_it = ((m_state == issue_pkg::ST_TRY_ISSUE) && v)
                 || (m_state == issue_pkg::ST_ISSUE_HELD);
        sel = (m_state == issue_pkg::ST_ISSUE_HELD) ? m_held : pkt;
        o1  = expect_operand(sel.instr[19:15]);
        o2  = expect_operand(sel.instr[24:20]);
        d   = expect_dispatch(sel, o1, o2, tail, try_it, t_rfull, t_afull);
        if (t_rst || t_flush) begin
            d         = '0;
            m_state   = issue_pkg::ST_TRY_ISSUE;
            m_held    = '0;
            m_last_wr = 1'b0;
        end else begin
            if (m_state == issue_pkg::ST_TRY_ISSUE && v && d.redirect && !d.rob_wr) begin
                m_held = pkt;
            end
            if (d.redirect && !d.rob_wr) begin
                m_state = issue_pkg::ST_ISSUE_HELD;   // Stalled
            end else if (d.redirect) begin
                m_state = issue_pkg::ST_SKIP_ONE;     // JAL issued
            end else begin
                m_state = issue_pkg::ST_TRY_ISSUE;
            end
            m_last_wr = d.rob_wr;
            if (d.rob_wr) begin
                m_last_rob = d.rob;
                m_last_tag = tail;
            end
        end
        exp_pending = d;
        chk_pending = 1'b1;

        rst         <= t_rst;
        flush       <= t_flush;
        instr_valid <= v;
        instr       <= pkt;
        rob_full    <= t_rfull;
        alu_full    <= t_afull;
        rob_tail    <= tail;
        rob_ready   <= t_rready;
        cdb_alu     <= t_cdb_alu;
        cdb_mem     <= t_cdb_mem;
        for (int i = 0; i < `NUM_REGS; i++) begin
            rename_tags[i] <= t_tags[i];
            reg_data[i]    <= t_regs[i];
        end
        for (int j = 0; j < `ROB_DEPTH; j++) begin
            rob_values[j] <= t_rvals[j];
        end
    end

    // Outputs settle after the rising edge and are sampled on the falling one
    always @(negedge clk_in) begin
        if (chk_now) begin
            check_value("fetch_redirect", fetch_redirect, exp_now.redirect);
            check_value("rob_wr_en", rob_wr_en, exp_now.rob_wr);
            check_value("alu_wr_en", alu_wr_en, exp_now.alu_wr);
            check_value("rename_wr_en", rename_wr_en, exp_now.ren_wr);
            if (exp_now.redirect) begin
                check_value("fetch_pc", fetch_pc, exp_now.fetch_pc);
            end
            if (exp_now.rob_wr) begin
                check_value("rob value_ready", rob_entry.value_ready, exp_now.rob.value_ready);
                check_value("rob dest", rob_entry.dest, exp_now.rob.dest);
                if (exp_now.rob.value_ready) begin
                    check_value("rob value", rob_entry.value, exp_now.rob.value);
                end
            end
            if (exp_now.alu_wr) begin
                check_value("alu op", alu_entry.op, exp_now.alu.op);
                check_value("alu dest", alu_entry.dest, exp_now.alu.dest);
                check_value("alu qj", alu_entry.qj, exp_now.alu.qj);
                check_value("alu qk", alu_entry.qk, exp_now.alu.qk);
                if (exp_now.alu.qj == 4'd0) begin
                    check_value("alu vj", alu_entry.vj, exp_now.alu.vj);
                end
                if (exp_now.alu.qk == 4'd0) begin
                    check_value("alu vk", alu_entry.vk, exp_now.alu.vk);
                end
            end
            if (exp_now.ren_wr) begin
                check_value("rename_wr", rename_wr, exp_now.ren);
            end
        end
    end

    always @(posedge clk_in) begin
        tmo_cnt <= tmo_cnt + 1;
        if (tmo_cnt >= TMO_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", TMO_LIMIT);
            $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        rand_state  = 32'h254a_d530;
        rst         = 1'b1;
        flush       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rob_full    = 1'b0;
        alu_full    = 1'b0;
        rob_tail    = '0;
        rob_ready   = '0;
        cdb_alu     = '0;
        cdb_mem     = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            rename_tags[i] = '0;
            reg_data[i]    = '0;
        end
        for (int j = 0; j < `ROB_DEPTH; j++) begin
            rob_values[j] = '0;
        end
        m_state     = issue_pkg::ST_TRY_ISSUE;
        m_held      = '0;
        m_last_wr   = 1'b0;
        m_last_rob  = '0;
        m_last_tag  = '0;
        exp_pending = '0;
        exp_now     = '0;
        chk_pending = 1'b0;
        chk_now     = 1'b0;
        full_kind   = 1'b0;
        full_left   = 0;
        cyc         = 0;
        n_checks    = 0;
        n_errors    = 0;
        tmo_cnt     = 0;

        wait (cyc >= NUM_CYCLES);
        repeat (3) @(posedge clk_in);   // Let the last dispatch be compared
        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
hw/issue_pkg.sv
hw/fetch_slot.sv
hw/rv_field_decode.sv
hw/operand_resolve.sv
hw/issue_ctrl.sv
hw/issue_unit.sv
bench/issue_tb.sv

// File: Bender.yml
package:
  name: issue_unit

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/issue_pkg.sv
      - hw/fetch_slot.sv
      - hw/rv_field_decode.sv
      - hw/operand_resolve.sv
      - hw/issue_ctrl.sv
      - hw/issue_unit.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/issue_tb.sv
